// File: Bender.yml
package:
  name: soc_dbus

export_include_dirs:
  - .

sources:
  - dbus_pkg.sv
  - periph_pkg.sv
  - dbus_decode.sv
  - ram_port.sv
  - gpio_regs.sv
  - ticker.sv
  - dbus_response.sv
  - soc_dbus_top.sv
  - target: test
    files:
      - tb_soc_dbus.sv

// File: dbus_decode.sv
`default_nettype none
`timescale 1ns/1ps

module dbus_decode (
    input  wire                  clk_bus_i,
    input  wire                  rst_n_i,
    input  dbus_pkg::dbus_req_t  master_req_i,
    input  wire                  busy_i,
    input  wire                  done_i,
    output dbus_pkg::dbus_route_t route_o,
    output dbus_pkg::dbus_resp_t  miss_resp_o,
    output logic                 master_stall_o
);

    logic                   accept;
    logic                   busy_q;
    dbus_pkg::dbus_target_e tgt;

    logic                   route_vld_q;
    dbus_pkg::dbus_target_e route_tgt_q;
    dbus_pkg::dbus_req_t    route_req_q;
    logic                   miss_vld_q;

    // busy_i lets the top hold off new work, the own flag covers the access
    assign accept = (master_req_i.read | master_req_i.write) & ~busy_q & ~busy_i;

    always_comb begin
        if ((master_req_i.addr & periph_pkg::WIN_MASK) == periph_pkg::RAM_BASE) begin
            tgt = dbus_pkg::TGT_RAM;
        end else if ((master_req_i.addr & periph_pkg::WIN_MASK) == periph_pkg::GPIO_BASE) begin
            tgt = dbus_pkg::TGT_GPIO;
        end else if ((master_req_i.addr & periph_pkg::WIN_MASK) == periph_pkg::TICK_BASE) begin
            tgt = dbus_pkg::TGT_TICK;
        end else begin
            tgt = dbus_pkg::TGT_NONE;
        end
    end

    always_ff @(posedge clk_bus_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            busy_q      <= 1'b0;
            route_vld_q <= 1'b0;
            miss_vld_q  <= 1'b0;
        end else begin
            if (accept) begin
                busy_q <= 1'b1;
            end else if (done_i) begin
                busy_q <= 1'b0;   // free one cycle after the strobe
            end
            route_vld_q <= accept;
            miss_vld_q  <= route_vld_q && (route_tgt_q == dbus_pkg::TGT_NONE);
        end
    end

    always_ff @(posedge clk_bus_i) begin
        if (accept) begin
            route_req_q <= master_req_i;
            route_tgt_q <= tgt;
        end
    end

    assign route_o = '{valid: route_vld_q, target: route_tgt_q, req: route_req_q};

    // nobody answers unmapped addresses, so reply here
    assign miss_resp_o = '{valid: miss_vld_q, error: miss_vld_q, rdata: '0};

    assign master_stall_o = busy_q;

    // a second route only goes out after the first one has completed
    a_single_route: assert property (
        @(posedge clk_bus_i) disable iff (!rst_n_i)
        route_o.valid |=> (!route_o.valid) throughout done_i[->1]
    );

endmodule

`default_nettype wire

// File: dbus_pkg.sv
`default_nettype none

`include "soc_dbus_settings.svh"

package dbus_pkg;

    // one master access, held for a single cycle
    typedef struct packed {
        logic                        read;
        logic                        write;
        logic [`SOC_DBUS_DW-1:0]     addr;
        logic [`SOC_DBUS_DW/8-1:0]   be;     // byte enables
        logic [`SOC_DBUS_DW-1:0]     wdata;
    } dbus_req_t;

    typedef enum logic [1:0] {
        TGT_RAM,
        TGT_GPIO,
        TGT_TICK,
        TGT_NONE    // unmapped
    } dbus_target_e;

    typedef struct packed {
        logic         valid;
        dbus_target_e target;
        dbus_req_t    req;
    } dbus_route_t;

    typedef struct packed {
        logic                    valid;
        logic                    error;
        logic [`SOC_DBUS_DW-1:0] rdata;
    } dbus_resp_t;

endpackage

`default_nettype wire

// File: dbus_response.sv
`default_nettype none
`timescale 1ns/1ps

module dbus_response (
    input  wire                  clk_bus_i,
    input  wire                  rst_n_i,
    input  dbus_pkg::dbus_resp_t ram_resp_i,
    input  dbus_pkg::dbus_resp_t gpio_resp_i,
    input  dbus_pkg::dbus_resp_t tick_resp_i,
    input  dbus_pkg::dbus_resp_t miss_resp_i,
    output dbus_pkg::dbus_resp_t master_resp_o,
    output logic                 done_o
);

    // drop a reply that is not strobing
    function automatic dbus_pkg::dbus_resp_t gate(input dbus_pkg::dbus_resp_t r);
        return r.valid ? r : '0;
    endfunction

    dbus_pkg::dbus_resp_t merged;
    logic                 vld_q;
    logic                 err_q;
    logic [$bits(merged.rdata)-1:0] data_q;

    always_comb begin
        merged = gate(ram_resp_i) | gate(gpio_resp_i) | gate(tick_resp_i) | gate(miss_resp_i);
    end

    always_ff @(posedge clk_bus_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            vld_q <= 1'b0;
        end else begin
            vld_q <= merged.valid;
        end
    end

    always_ff @(posedge clk_bus_i) begin
        err_q  <= merged.error;
        data_q <= merged.rdata;
    end

    assign master_resp_o = '{valid: vld_q, error: err_q, rdata: data_q};
    assign done_o        = vld_q;   // releases the decoder

    a_one_resp: assert property (
        @(posedge clk_bus_i) disable iff (!rst_n_i)
        $onehot0({ram_resp_i.valid, gpio_resp_i.valid, tick_resp_i.valid, miss_resp_i.valid})
    );

endmodule

`default_nettype wire

// File: gpio_regs.sv
`default_nettype none
`timescale 1ns/1ps

`include "soc_dbus_settings.svh"

module gpio_regs (
    input  wire                         clk_bus_i,
    input  wire                         rst_n_i,
    input  dbus_pkg::dbus_route_t       route_i,
    input  wire [`SOC_DBUS_GPIO_W-1:0]  gpio_in_i,
    output logic [`SOC_DBUS_GPIO_W-1:0] gpio_out_o,
    output dbus_pkg::dbus_resp_t        resp_o
);

    localparam int DW = `SOC_DBUS_DW;
    localparam int GW = `SOC_DBUS_GPIO_W;

    logic                         hit;
    logic [periph_pkg::OFS_W-1:0] ofs;
    logic [GW-1:0]                out_q;
    logic [GW-1:0]                in_meta_q;
    logic [GW-1:0]                in_sync_q;
    logic                         vld_q;
    logic                         err_q;
    logic [DW-1:0]                data_q;

    assign hit = route_i.valid && (route_i.target == dbus_pkg::TGT_GPIO);
    assign ofs = route_i.req.addr[periph_pkg::OFS_W-1:0];

    always_ff @(posedge clk_bus_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            out_q     <= '0;
            in_meta_q <= '0;
            in_sync_q <= '0;
            vld_q     <= 1'b0;
        end else begin
            in_meta_q <= gpio_in_i;   // pins are asynchronous
            in_sync_q <= in_meta_q;
            vld_q     <= hit;
            if (hit && route_i.req.write && ofs == periph_pkg::GPIO_OUT_OFS) begin
                for (int b = 0; b < GW/8; b++) begin
                    if (route_i.req.be[b]) begin
                        out_q[8*b +: 8] <= route_i.req.wdata[8*b +: 8];
                    end
                end
            end
        end
    end

    always_ff @(posedge clk_bus_i) begin
        if (hit) begin
            err_q <= route_i.req.write && (ofs == periph_pkg::GPIO_IN_OFS);
            if (!route_i.req.read) begin
                data_q <= '0;
            end else if (ofs == periph_pkg::GPIO_OUT_OFS) begin
                data_q <= DW'(out_q);
            end else if (ofs == periph_pkg::GPIO_IN_OFS) begin
                data_q <= DW'(in_sync_q);
            end else begin
                data_q <= '0;
            end
        end
    end

    assign gpio_out_o = out_q;
    assign resp_o     = '{valid: vld_q, error: err_q, rdata: data_q};

endmodule

`default_nettype wire

// File: periph_pkg.sv
`default_nettype none

`include "soc_dbus_settings.svh"

package periph_pkg;

    // all windows are 4 KB
    localparam int OFS_W = 12;

    localparam logic [`SOC_DBUS_DW-1:0] WIN_MASK  = 32'hFFFF_F000;

    localparam logic [`SOC_DBUS_DW-1:0] RAM_BASE  = 32'h0000_0000;
    localparam logic [`SOC_DBUS_DW-1:0] GPIO_BASE = 32'hBFD0_0000;
    localparam logic [`SOC_DBUS_DW-1:0] TICK_BASE = 32'hBFD0_1000;

    // gpio registers
    localparam logic [OFS_W-1:0] GPIO_OUT_OFS = 12'h000;
    localparam logic [OFS_W-1:0] GPIO_IN_OFS  = 12'h004;   // read only

    // ticker registers
    localparam logic [OFS_W-1:0] TICK_COUNT_OFS = 12'h000;
    localparam logic [OFS_W-1:0] TICK_CMP_OFS   = 12'h004;

endpackage

`default_nettype wire

// File: ram_port.sv
`default_nettype none
`timescale 1ns/1ps

`include "soc_dbus_settings.svh"

module ram_port (
    input  wire                   clk_bus_i,
    input  wire                   rst_n_i,
    input  dbus_pkg::dbus_route_t route_i,
    output dbus_pkg::dbus_resp_t  resp_o
);

    localparam int DW = `SOC_DBUS_DW;
    localparam int AW = $clog2(`SOC_DBUS_RAM_WORDS);

    logic [DW-1:0] mem [`SOC_DBUS_RAM_WORDS];

    logic          hit;
    logic [AW-1:0] idx;
    logic [DW-1:0] rdata_q;
    logic [DW-1:0] data_q;
    logic          rd_q;
    logic          wait_q;
    logic          vld_q;

    assign hit = route_i.valid && (route_i.target == dbus_pkg::TGT_RAM);
    assign idx = route_i.req.addr[AW+1:2];   // word address

    always_ff @(posedge clk_bus_i) begin
        if (hit && route_i.req.write) begin
            for (int b = 0; b < DW/8; b++) begin
                if (route_i.req.be[b]) begin
                    mem[idx][8*b +: 8] <= route_i.req.wdata[8*b +: 8];
                end
            end
        end
        if (hit) begin
            rdata_q <= mem[idx];
            rd_q    <= route_i.req.read;
        end
        if (wait_q) begin
            data_q <= rd_q ? rdata_q : '0;   // writes answer with zero
        end
    end

    // one wait cycle like the external sram
    always_ff @(posedge clk_bus_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wait_q <= 1'b0;
            vld_q  <= 1'b0;
        end else begin
            wait_q <= hit;
            vld_q  <= wait_q;
        end
    end

    assign resp_o = '{valid: vld_q, error: 1'b0, rdata: data_q};

    a_ram_rw_excl: assert property (
        @(posedge clk_bus_i) disable iff (!rst_n_i)
        hit |-> !(route_i.req.read && route_i.req.write)
    );

endmodule

`default_nettype wire

// File: soc_dbus.f
+incdir+.
dbus_pkg.sv
periph_pkg.sv
dbus_decode.sv
ram_port.sv
gpio_regs.sv
ticker.sv
dbus_response.sv
soc_dbus_top.sv
tb_soc_dbus.sv

// File: soc_dbus_settings.svh
`ifndef SOC_DBUS_SETTINGS_SVH
`define SOC_DBUS_SETTINGS_SVH

// data and address width of the bus
`define SOC_DBUS_DW 32

// on-chip RAM depth in 32-bit words, 4 KB
`define SOC_DBUS_RAM_WORDS 1024

// gpio pin count, whole bytes only
`define SOC_DBUS_GPIO_W 32

`endif

// File: soc_dbus_top.sv
`default_nettype none
`timescale 1ns/1ps

`include "soc_dbus_settings.svh"

module soc_dbus_top (
    input  wire                         clk_bus_i,
    input  wire                         rst_n_i,
    input  dbus_pkg::dbus_req_t         master_req_i,
    output logic                        master_stall_o,
    output dbus_pkg::dbus_resp_t        master_resp_o,
    input  wire [`SOC_DBUS_GPIO_W-1:0]  gpio_in_i,
    output logic [`SOC_DBUS_GPIO_W-1:0] gpio_out_o,
    output logic                        tick_irq_o
);

    dbus_pkg::dbus_route_t route;
    dbus_pkg::dbus_resp_t  ram_resp;
    dbus_pkg::dbus_resp_t  gpio_resp;
    dbus_pkg::dbus_resp_t  tick_resp;
    dbus_pkg::dbus_resp_t  miss_resp;
    logic                  done;

    dbus_decode u_decode (
        .clk_bus_i      (clk_bus_i),
        .rst_n_i        (rst_n_i),
        .master_req_i   (master_req_i),
        .busy_i         (master_resp_o.valid),   // strobe cycle still counts as busy
        .done_i         (done),
        .route_o        (route),
        .miss_resp_o    (miss_resp),
        .master_stall_o (master_stall_o)
    );

    ram_port u_ram (
        .clk_bus_i (clk_bus_i),
        .rst_n_i   (rst_n_i),
        .route_i   (route),
        .resp_o    (ram_resp)
    );

    gpio_regs u_gpio (
        .clk_bus_i  (clk_bus_i),
        .rst_n_i    (rst_n_i),
        .route_i    (route),
        .gpio_in_i  (gpio_in_i),
        .gpio_out_o (gpio_out_o),
        .resp_o     (gpio_resp)
    );

    ticker u_ticker (
        .clk_bus_i  (clk_bus_i),
        .rst_n_i    (rst_n_i),
        .route_i    (route),
        .tick_irq_o (tick_irq_o),
        .resp_o     (tick_resp)
    );

    dbus_response u_response (
        .clk_bus_i     (clk_bus_i),
        .rst_n_i       (rst_n_i),
        .ram_resp_i    (ram_resp),
        .gpio_resp_i   (gpio_resp),
        .tick_resp_i   (tick_resp),
        .miss_resp_i   (miss_resp),
        .master_resp_o (master_resp_o),
        .done_o        (done)
    );

endmodule

`default_nettype wire

// File: tb_soc_dbus.sv
`default_nettype none
`timescale 1ns/1ps

`include "soc_dbus_settings.svh"

module tb_soc_dbus;

    localparam int DW             = `SOC_DBUS_DW;
    localparam int GW             = `SOC_DBUS_GPIO_W;
    localparam int RAM_AW         = $clog2(`SOC_DBUS_RAM_WORDS);
    localparam int RAM_TEST_WORDS = 64;
    localparam int WAIT_LIMIT     = 100;
    localparam int IRQ_LIMIT      = 200;
    localparam int DRIVE_DLY      = 2;

    localparam logic [DW-1:0] GPIO_OUT_ADDR  = periph_pkg::GPIO_BASE | DW'(periph_pkg::GPIO_OUT_OFS);
    localparam logic [DW-1:0] GPIO_IN_ADDR   = periph_pkg::GPIO_BASE | DW'(periph_pkg::GPIO_IN_OFS);
    localparam logic [DW-1:0] TICK_COUNT_ADDR =
        periph_pkg::TICK_BASE | DW'(periph_pkg::TICK_COUNT_OFS);
    localparam logic [DW-1:0] TICK_CMP_ADDR  = periph_pkg::TICK_BASE | DW'(periph_pkg::TICK_CMP_OFS);

    logic                 clk_bus = 1'b0;
    logic                 rst_n;
    dbus_pkg::dbus_req_t  master_req_i;
    logic                 master_stall_o;
    dbus_pkg::dbus_resp_t master_resp_o;
    logic [GW-1:0]        gpio_in_i;
    logic [GW-1:0]        gpio_out_o;
    logic                 tick_irq_o;

    // reference state
    logic [DW-1:0]        ram_model [`SOC_DBUS_RAM_WORDS];
    logic [GW-1:0]        gpio_out_model = '0;
    logic [DW-1:0]        cmp_model = '0;

    dbus_pkg::dbus_resp_t exp_resp;
    logic                 exp_pending = 1'b0;
    logic                 exp_skip = 1'b0;
    logic                 prev_strobe = 1'b0;
    int                   errors = 0;
    int                   timeouts = 0;
    int                   cycle_cnt = 0;

    soc_dbus_top UUT (
        .clk_bus_i      (clk_bus),
        .rst_n_i        (rst_n),
        .master_req_i   (master_req_i),
        .master_stall_o (master_stall_o),
        .master_resp_o  (master_resp_o),
        .gpio_in_i      (gpio_in_i),
        .gpio_out_o     (gpio_out_o),
        .tick_irq_o     (tick_irq_o)
    );

    always #10 clk_bus = ~clk_bus;

    always @(posedge clk_bus) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    task automatic check_value(input string name, input logic [DW-1:0] got,
                               input logic [DW-1:0] exp);
        if (got !== exp) begin
            $display("ERROR %s: got 0x%08h expected 0x%08h at %0t", name, got, exp, $time);
            errors++;
        end
    endtask

    task automatic next_cycle();
        @(posedge clk_bus);
        #(DRIVE_DLY);
    endtask

    function automatic dbus_pkg::dbus_target_e target_of(input logic [DW-1:0] addr);
        if ((addr & periph_pkg::WIN_MASK) == periph_pkg::RAM_BASE) begin
            return dbus_pkg::TGT_RAM;
        end else if ((addr & periph_pkg::WIN_MASK) == periph_pkg::GPIO_BASE) begin
            return dbus_pkg::TGT_GPIO;
        end else if ((addr & periph_pkg::WIN_MASK) == periph_pkg::TICK_BASE) begin
            return dbus_pkg::TGT_TICK;
        end
        return dbus_pkg::TGT_NONE;
    endfunction

    function automatic logic [DW-1:0] merge_bytes(input logic [DW-1:0] old,
                                                  input logic [DW-1:0] wdata,
                                                  input logic [DW/8-1:0] be);
        logic [DW-1:0] r;
        r = old;
        for (int b = 0; b < DW/8; b++) begin
            if (be[b]) begin
                r[8*b +: 8] = wdata[8*b +: 8];
            end
        end
        return r;
    endfunction

    // pattern spreads all address bits over the word
    function automatic logic [DW-1:0] fill_word(input logic [DW-1:0] addr);
        return (addr * 32'h9E37_79B9) ^ {addr[15:0], addr[31:16]};
    endfunction

    // expected reply from the memory map rules
    function automatic dbus_pkg::dbus_resp_t expected_resp(input logic rd,
                                                           input logic [DW-1:0] addr);
        dbus_pkg::dbus_resp_t r;
        logic [11:0]          ofs;
        r       = '0;
        r.valid = 1'b1;
        ofs     = addr[11:0];
        case (target_of(addr))
            dbus_pkg::TGT_RAM: begin
                if (rd) begin
                    r.rdata = ram_model[addr[RAM_AW+1:2]];
                end
            end
            dbus_pkg::TGT_GPIO: begin
                if (!rd && ofs == periph_pkg::GPIO_IN_OFS) begin
                    r.error = 1'b1;   // input register is read only
                end else if (rd && ofs == periph_pkg::GPIO_OUT_OFS) begin
                    r.rdata = DW'(gpio_out_model);
                end else if (rd && ofs == periph_pkg::GPIO_IN_OFS) begin
                    r.rdata = DW'(gpio_in_i);
                end
            end
            dbus_pkg::TGT_TICK: begin
                if (rd && ofs == periph_pkg::TICK_CMP_OFS) begin
                    r.rdata = cmp_model;
                end
            end
            default: begin
                r.error = 1'b1;
            end
        endcase
        return r;
    endfunction

    task automatic update_model(input logic [DW-1:0] addr, input logic [DW/8-1:0] be,
                                input logic [DW-1:0] wdata);
        logic [11:0] ofs;
        ofs = addr[11:0];
        case (target_of(addr))
            dbus_pkg::TGT_RAM: begin
                ram_model[addr[RAM_AW+1:2]] = merge_bytes(ram_model[addr[RAM_AW+1:2]], wdata, be);
            end
            dbus_pkg::TGT_GPIO: begin
                if (ofs == periph_pkg::GPIO_OUT_OFS) begin
                    gpio_out_model = GW'(merge_bytes(DW'(gpio_out_model), wdata, be));
                end
            end
            dbus_pkg::TGT_TICK: begin
                if (ofs == periph_pkg::TICK_CMP_OFS) begin
                    cmp_model = merge_bytes(cmp_model, wdata, be);
                end
            end
            default: begin
            end
        endcase
    endtask

    // early presents the request on every cycle that stall is high
    task automatic do_access(input logic rd, input logic [DW-1:0] addr,
                             input logic [DW/8-1:0] be, input logic [DW-1:0] wdata,
                             input logic early, output logic [DW-1:0] rdata);
        dbus_pkg::dbus_req_t req;
        int                  waited;
        int                  lat;
        int                  exp_lat;
        logic                got;
        req     = '{read: rd, write: !rd, addr: addr, be: be, wdata: wdata};
        exp_lat = (target_of(addr) == dbus_pkg::TGT_RAM) ? 3 : 2;
        rdata   = '0;
        if (timeouts == 0) begin
            if (early) begin
                master_req_i = req;
            end
            waited = 0;
            while (master_stall_o && waited < WAIT_LIMIT) begin
                next_cycle();
                waited++;
            end
            if (master_stall_o) begin
                $display("timeout: master_stall_o stayed high for %0d cycles", WAIT_LIMIT);
                timeouts++;
                master_req_i = '0;
            end else begin
                exp_resp    = expected_resp(rd, addr);
                exp_skip    = rd && target_of(addr) == dbus_pkg::TGT_TICK
                              && addr[11:0] == periph_pkg::TICK_COUNT_OFS;
                exp_pending = 1'b1;
                if (!rd) begin
                    update_model(addr, be, wdata);
                end
                master_req_i = req;
                next_cycle();   // accepting edge
                check_value("master_stall_o", master_stall_o, 1'b1);
                if (!early) begin
                    master_req_i = '0;
                end
                lat = 0;
                got = 1'b0;
                while (!got && lat < WAIT_LIMIT) begin
                    next_cycle();
                    lat++;
                    got = master_resp_o.valid;
                end
                master_req_i = '0;
                if (!got) begin
                    $display("timeout: no response strobe for address 0x%08h", addr);
                    timeouts++;
                    exp_pending = 1'b0;
                end else begin
                    check_value("master_resp_o.valid latency", lat, exp_lat);
                    rdata = master_resp_o.rdata;
                end
            end
        end
    endtask

    task automatic write_word(input logic [DW-1:0] addr, input logic [DW/8-1:0] be,
                              input logic [DW-1:0] wdata);
        logic [DW-1:0] ignored_data;
        do_access(1'b0, addr, be, wdata, 1'b0, ignored_data);
    endtask

    task automatic read_word(input logic [DW-1:0] addr, output logic [DW-1:0] rdata);
        do_access(1'b1, addr, '1, '0, 1'b0, rdata);
    endtask

    task automatic probe_unmapped(input logic [DW-1:0] addr);
        logic [DW-1:0] data;
        write_word(addr, 4'hF, $urandom);
        read_word(addr, data);
    endtask

    task automatic finish_run();
        $display("errors: %0d, timeouts: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    endtask

    // compares every response strobe with the reference
    always @(posedge clk_bus) begin
        #1;
        if (rst_n && prev_strobe) begin
            check_value("master_stall_o", master_stall_o, 1'b0);
        end
        if (rst_n && master_resp_o.valid) begin
            if (!exp_pending) begin
                $display("response strobe without an outstanding request at %0t", $time);
                errors++;
            end else begin
                check_value("master_resp_o.error", master_resp_o.error, exp_resp.error);
                if (!exp_skip) begin
                    check_value("master_resp_o.rdata", master_resp_o.rdata, exp_resp.rdata);
                end
                exp_pending = 1'b0;
            end
        end
        prev_strobe = rst_n && master_resp_o.valid;
    end

    initial begin
        logic [DW-1:0]   addr;
        logic [DW-1:0]   data;
        logic [DW/8-1:0] be;
        int              start;
        int              waited;
        void'($urandom(75325));
        rst_n        = 1'b0;
        master_req_i = '0;
        gpio_in_i    = '0;
        repeat (8) begin
            next_cycle();
        end
        rst_n = 1'b1;
        check_value("master_stall_o", master_stall_o, 1'b0);
        check_value("master_resp_o.valid", master_resp_o.valid, 1'b0);
        check_value("gpio_out_o", gpio_out_o, '0);
        check_value("tick_irq_o", tick_irq_o, 1'b0);

        // ram, known contents first
        for (int i = 0; i < RAM_TEST_WORDS; i++) begin
            addr = periph_pkg::RAM_BASE + 4 * i;
            write_word(addr, 4'hF, fill_word(addr));
        end
        addr = periph_pkg::RAM_BASE + 4 * (`SOC_DBUS_RAM_WORDS - 1);
        write_word(addr, 4'hF, fill_word(addr));
        read_word(addr, data);
        for (int i = 0; i < 200; i++) begin
            addr = periph_pkg::RAM_BASE + 4 * $urandom_range(RAM_TEST_WORDS - 1);
            write_word(addr, 4'($urandom_range(15)), $urandom);
            read_word(addr, data);
        end

        // gpio
        for (int i = 0; i < 8; i++) begin
            be = 4'($urandom_range(15));
            write_word(GPIO_OUT_ADDR, be, $urandom);
            check_value("gpio_out_o", gpio_out_o, gpio_out_model);
            read_word(GPIO_OUT_ADDR, data);
        end
        gpio_in_i = $urandom;
        repeat (3) begin
            next_cycle();   // two flop input sync
        end
        read_word(GPIO_IN_ADDR, data);
        write_word(GPIO_IN_ADDR, 4'hF, $urandom);
        check_value("gpio_out_o", gpio_out_o, gpio_out_model);

        // unmapped windows
        probe_unmapped(32'h0000_1000);
        probe_unmapped(32'hBFD0_2000);
        probe_unmapped(32'hBFCF_FFFC);
        for (int i = 0; i < 10; i++) begin
            addr = $urandom;
            if (target_of(addr) == dbus_pkg::TGT_NONE) begin
                probe_unmapped(addr);
            end
        end

        // ticker
        start = cycle_cnt;
        write_word(TICK_COUNT_ADDR, 4'hF, 32'hFFFF_FFFF);
        repeat (20) begin
            next_cycle();
        end
        read_word(TICK_COUNT_ADDR, data);
        check_value("master_resp_o.rdata count in range",
                    (data != 0 && data < DW'(cycle_cnt - start)), 1'b1);
        write_word(TICK_CMP_ADDR, 4'hF, 32'd50);
        read_word(TICK_CMP_ADDR, data);
        write_word(TICK_COUNT_ADDR, 4'hF, 32'h0);
        waited = 0;
        while (!tick_irq_o && waited < IRQ_LIMIT) begin
            next_cycle();
            waited++;
        end
        if (!tick_irq_o) begin
            $display("tick_irq_o did not rise within %0d cycles of the compare setup", IRQ_LIMIT);
            errors++;
        end
        write_word(TICK_COUNT_ADDR, 4'hF, 32'h0);
        check_value("tick_irq_o", tick_irq_o, 1'b0);

        // requests held while stall is high
        for (int i = 0; i < 40; i++) begin
            addr = periph_pkg::RAM_BASE + 4 * $urandom_range(RAM_TEST_WORDS - 1);
            do_access(1'($urandom_range(1)), addr, 4'($urandom_range(15)), $urandom, 1'b1, data);
        end
        do_access(1'b1, GPIO_OUT_ADDR, 4'hF, '0, 1'b1, data);
        for (int i = 0; i < RAM_TEST_WORDS; i++) begin
            read_word(periph_pkg::RAM_BASE + 4 * i, data);
        end
        repeat (5) begin
            next_cycle();   // stray strobes would show here
        end
        finish_run();
    end

endmodule

`default_nettype wire

// File: ticker.sv
`default_nettype none
`timescale 1ns/1ps

`include "soc_dbus_settings.svh"

module ticker (
    input  wire                   clk_bus_i,
    input  wire                   rst_n_i,
    input  dbus_pkg::dbus_route_t route_i,
    output logic                  tick_irq_o,
    output dbus_pkg::dbus_resp_t  resp_o
);

    localparam int DW = `SOC_DBUS_DW;

    logic                         hit;
    logic [periph_pkg::OFS_W-1:0] ofs;
    logic                         cnt_wr;
    logic                         cmp_wr;
    logic [DW-1:0]                count_q;
    logic [DW-1:0]                cmp_q;
    logic                         irq_q;
    logic                         vld_q;
    logic [DW-1:0]                data_q;

    assign hit    = route_i.valid && (route_i.target == dbus_pkg::TGT_TICK);
    assign ofs    = route_i.req.addr[periph_pkg::OFS_W-1:0];
    assign cnt_wr = hit && route_i.req.write && (ofs == periph_pkg::TICK_COUNT_OFS);
    assign cmp_wr = hit && route_i.req.write && (ofs == periph_pkg::TICK_CMP_OFS);

    always_ff @(posedge clk_bus_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            count_q <= '0;
            cmp_q   <= '0;
            irq_q   <= 1'b0;
            vld_q   <= 1'b0;
        end else begin
            count_q <= cnt_wr ? '0 : count_q + 1'b1;   // any count write clears
            if (cmp_wr) begin
                for (int b = 0; b < DW/8; b++) begin
                    if (route_i.req.be[b]) begin
                        cmp_q[8*b +: 8] <= route_i.req.wdata[8*b +: 8];
                    end
                end
            end
            if (cnt_wr) begin
                irq_q <= 1'b0;
            end else if (cmp_q != '0 && count_q == cmp_q) begin
                irq_q <= 1'b1;   // sticky
            end
            vld_q <= hit;
        end
    end

    always_ff @(posedge clk_bus_i) begin
        if (hit) begin
            if (route_i.req.read && ofs == periph_pkg::TICK_COUNT_OFS) begin
                data_q <= count_q;
            end else if (route_i.req.read && ofs == periph_pkg::TICK_CMP_OFS) begin
                data_q <= cmp_q;
            end else begin
                data_q <= '0;
            end
        end
    end

    assign tick_irq_o = irq_q;
    assign resp_o     = '{valid: vld_q, error: 1'b0, rdata: data_q};

endmodule

`default_nettype wire
